// ==== logic/midi_pkg.sv ====
package midi_pkg;

    ////////////////////
    // Status byte nibbles
    ////////////////////

    // Channel voice messages carry the channel in the low nibble
    localparam logic [3:0] STATUS_NOTE_OFF      = 4'h8;
    localparam logic [3:0] STATUS_NOTE_ON       = 4'h9;
    localparam logic [3:0] STATUS_POLY_AT       = 4'hA;
    localparam logic [3:0] STATUS_CTRL_CHANGE   = 4'hB;
    localparam logic [3:0] STATUS_PROG_CHANGE   = 4'hC;
    localparam logic [3:0] STATUS_CHAN_PRESSURE = 4'hD;
    localparam logic [3:0] STATUS_PITCH_BEND    = 4'hE;
    // System common and realtime
    localparam logic [3:0] STATUS_SYSTEM        = 4'hF;

    // F8 and above are realtime and never touch running status
    localparam logic [7:0] STATUS_REALTIME_MIN  = 8'hF8;

    ////////////////////
    // Message tracking
    ////////////////////

    // Running status kind
    typedef enum logic [2:0] {
        MSG_NONE,
        MSG_NOTE_OFF,
        MSG_NOTE_ON,
        MSG_POLY_AT,
        MSG_CTRL_CHANGE,
        MSG_PROG_CHANGE,
        MSG_CHAN_PRESSURE,
        MSG_PITCH_BEND
    } msg_kind_t;

    // Position of a byte within its message
    typedef enum logic [1:0] {
        BYTE_IGNORED,
        BYTE_FIRST,
        BYTE_SECOND
    } byte_class_t;

    // Tracker to decoders
    typedef struct packed {
        msg_kind_t   kind;
        logic [3:0]  channel;
        byte_class_t byte_class;
        logic [6:0]  data;
    } byte_info_t;

    ////////////////////
    // Decoded events
    ////////////////////

    typedef struct packed {
        logic [3:0] channel;
        logic [6:0] controller;
        logic [6:0] value;
    } cc_event_t;

    typedef struct packed {
        logic [3:0] channel;
        logic [6:0] program_num;
    } pc_event_t;

    // on is clear for Note Off and for Note On with velocity zero
    typedef struct packed {
        logic       on;
        logic [3:0] channel;
        logic [6:0] key;
        logic [6:0] velocity;
    } note_event_t;

endpackage

// ==== logic/midi_status_tracker.sv ====
module midi_status_tracker (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  logic                 trig_seq,
    input  logic [7:0]           seq_databyte,
    output midi_pkg::byte_info_t byte_info,
    output logic                 byte_strobe
);

    // Running status
    midi_pkg::msg_kind_t   run_kind;
    logic [3:0]            run_channel;
    // Low when the next data byte is a first byte
    logic                  data_pos;

    // Classification of the byte on seq_databyte
    midi_pkg::msg_kind_t   status_kind;
    midi_pkg::byte_class_t next_class;
    logic                  is_status;
    logic                  is_realtime;
    logic                  is_system;
    logic                  one_data_byte;

    // Upper status nibble to message kind
    function automatic midi_pkg::msg_kind_t kind_of(input logic [3:0] nibble);
        midi_pkg::msg_kind_t kind;
        case (nibble)
            midi_pkg::STATUS_NOTE_OFF:      kind = midi_pkg::MSG_NOTE_OFF;
            midi_pkg::STATUS_NOTE_ON:       kind = midi_pkg::MSG_NOTE_ON;
            midi_pkg::STATUS_POLY_AT:       kind = midi_pkg::MSG_POLY_AT;
            midi_pkg::STATUS_CTRL_CHANGE:   kind = midi_pkg::MSG_CTRL_CHANGE;
            midi_pkg::STATUS_PROG_CHANGE:   kind = midi_pkg::MSG_PROG_CHANGE;
            midi_pkg::STATUS_CHAN_PRESSURE: kind = midi_pkg::MSG_CHAN_PRESSURE;
            midi_pkg::STATUS_PITCH_BEND:    kind = midi_pkg::MSG_PITCH_BEND;
            default:                        kind = midi_pkg::MSG_NONE;
        endcase
        return kind;
    endfunction

    ////////////////////
    // Byte classification
    ////////////////////

    always_comb begin
        is_status   = seq_databyte[7];
        is_realtime = seq_databyte >= midi_pkg::STATUS_REALTIME_MIN;
        // F0..F7, cancels running status
        is_system   = is_status && !is_realtime &&
                      (seq_databyte[7:4] == midi_pkg::STATUS_SYSTEM);
        status_kind = kind_of(seq_databyte[7:4]);

        // Program change and channel pressure carry a single data byte
        one_data_byte = (run_kind == midi_pkg::MSG_PROG_CHANGE) ||
                        (run_kind == midi_pkg::MSG_CHAN_PRESSURE);

        if (is_status || run_kind == midi_pkg::MSG_NONE) begin
            next_class = midi_pkg::BYTE_IGNORED;
        end else if (one_data_byte || !data_pos) begin
            next_class = midi_pkg::BYTE_FIRST;
        end else begin
            next_class = midi_pkg::BYTE_SECOND;
        end
    end

    ////////////////////
    // Running status
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            run_kind    <= midi_pkg::MSG_NONE;
            run_channel <= '0;
            data_pos    <= 1'b0;
        end else if (trig_seq) begin
            if (is_realtime) begin
                // Realtime leaves everything as is
                data_pos <= data_pos;
            end else if (is_system) begin
                run_kind <= midi_pkg::MSG_NONE;
                data_pos <= 1'b0;
            end else if (is_status) begin
                run_kind    <= status_kind;
                run_channel <= seq_databyte[3:0];
                data_pos    <= 1'b0;
            end else if (next_class == midi_pkg::BYTE_FIRST && !one_data_byte) begin
                data_pos <= 1'b1;
            end else if (next_class == midi_pkg::BYTE_SECOND) begin
                // Wrap for running status
                data_pos <= 1'b0;
            end
        end
    end

    // Strobe only for data bytes that belong to a message
    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            byte_strobe <= 1'b0;
        end else begin
            byte_strobe <= trig_seq && (next_class != midi_pkg::BYTE_IGNORED);
        end
    end

    // Classified byte, qualified by byte_strobe
    always_ff @(posedge clk) begin
        if (trig_seq && next_class != midi_pkg::BYTE_IGNORED) begin
            byte_info <= '{kind:       run_kind,
                           channel:    run_channel,
                           byte_class: next_class,
                           data:       seq_databyte[6:0]};
        end
    end

endmodule

// ==== logic/controller_cmd_inst.sv ====
module controller_cmd_inst (
    input  logic                 clk,
    input  logic                 reset_reg_N,
    input  midi_pkg::byte_info_t byte_info,
    input  logic                 byte_strobe,
    output logic                 cc_strobe,
    output midi_pkg::cc_event_t  cc_event,
    output logic                 pc_strobe,
    output midi_pkg::pc_event_t  pc_event
);

    // Controller number waiting for its value byte
    logic [6:0] cc_controller;
    logic       is_cc;
    logic       is_pc;

    // Only strobed bytes of the matching kind
    assign is_cc = byte_strobe && (byte_info.kind == midi_pkg::MSG_CTRL_CHANGE);
    assign is_pc = byte_strobe && (byte_info.kind == midi_pkg::MSG_PROG_CHANGE);

    ////////////////////
    // Control Change
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            cc_strobe     <= 1'b0;
            cc_event      <= '0;
            cc_controller <= '0;
        end else begin
            cc_strobe <= 1'b0;
            if (is_cc) begin
                if (byte_info.byte_class == midi_pkg::BYTE_FIRST) begin
                    // Controller number waits for the value byte
                    cc_controller <= byte_info.data;
                end else if (byte_info.byte_class == midi_pkg::BYTE_SECOND) begin
                    cc_event <= '{channel:    byte_info.channel,
                                  controller: cc_controller,
                                  value:      byte_info.data};
                    cc_strobe <= 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Program Change
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            pc_strobe <= 1'b0;
            pc_event  <= '0;
        end else begin
            pc_strobe <= 1'b0;
            // Single data byte completes the message
            if (is_pc && byte_info.byte_class == midi_pkg::BYTE_FIRST) begin
                pc_event  <= '{channel:     byte_info.channel,
                               program_num: byte_info.data};
                pc_strobe <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/note_cmd_decoder.sv ====
module note_cmd_decoder (
    input  logic                  clk,
    input  logic                  reset_reg_N,
    input  midi_pkg::byte_info_t  byte_info,
    input  logic                  byte_strobe,
    output logic                  note_strobe,
    output midi_pkg::note_event_t note_event
);

    // Key number waiting for its velocity byte
    logic [6:0] note_key;
    logic       is_note;
    logic       is_note_on;
    logic       note_on_now;

    ////////////////////
    // Message qualification
    ////////////////////

    always_comb begin
        is_note_on = byte_info.kind == midi_pkg::MSG_NOTE_ON;
        // Note On and Note Off share one byte layout
        is_note    = byte_strobe &&
                     (is_note_on || byte_info.kind == midi_pkg::MSG_NOTE_OFF);
        // Note On with velocity zero counts as Note Off
        note_on_now = is_note_on && (byte_info.data != 7'd0);
    end

    ////////////////////
    // Key and velocity
    ////////////////////

    always_ff @(posedge clk) begin
        if (!reset_reg_N) begin
            note_strobe <= 1'b0;
            note_event  <= '0;
            note_key    <= '0;
        end else begin
            note_strobe <= 1'b0;
            if (is_note) begin
                case (byte_info.byte_class)
                    midi_pkg::BYTE_FIRST: begin
                        // Key held until the velocity arrives
                        note_key <= byte_info.data;
                    end
                    midi_pkg::BYTE_SECOND: begin
                        // Velocity completes the event
                        note_event <= '{on:       note_on_now,
                                        channel:  byte_info.channel,
                                        key:      note_key,
                                        velocity: byte_info.data};
                        note_strobe <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== logic/midi_cmd_top.sv ====
module midi_cmd_top (
    input  logic                  clk,
    input  logic                  reset_reg_N,
    input  logic                  trig_seq,
    input  logic [7:0]            seq_databyte,
    output logic                  cc_strobe,
    output midi_pkg::cc_event_t   cc_event,
    output logic                  pc_strobe,
    output midi_pkg::pc_event_t   pc_event,
    output logic                  note_strobe,
    output midi_pkg::note_event_t note_event
);

    // Classified data byte, shared by both decoders
    midi_pkg::byte_info_t byte_info;
    logic                 byte_strobe;

    ////////////////////
    // Running status and byte position
    ////////////////////

    midi_status_tracker i_midi_status_tracker (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .trig_seq     (trig_seq),
        .seq_databyte (seq_databyte),
        .byte_info    (byte_info),
        .byte_strobe  (byte_strobe)
    );

    ////////////////////
    // Decoders
    ////////////////////

    // CC and program change
    controller_cmd_inst i_controller_cmd_inst (
        .clk         (clk),
        .reset_reg_N (reset_reg_N),
        .byte_info   (byte_info),
        .byte_strobe (byte_strobe),
        .cc_strobe   (cc_strobe),
        .cc_event    (cc_event),
        .pc_strobe   (pc_strobe),
        .pc_event    (pc_event)
    );

    // Note on and note off
    note_cmd_decoder i_note_cmd_decoder (
        .clk         (clk),
        .reset_reg_N (reset_reg_N),
        .byte_info   (byte_info),
        .byte_strobe (byte_strobe),
        .note_strobe (note_strobe),
        .note_event  (note_event)
    );

endmodule

// ==== verification/midi_cmd_tb.sv ====
module midi_cmd_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // Event expected two cycles after a byte
    typedef enum logic [1:0] {
        EXP_NONE,
        EXP_CC,
        EXP_PC,
        EXP_NOTE
    } exp_kind_t;

    // One stimulus byte with the event it should complete
    // field_a holds the controller, program or key
    // field_b holds the value or velocity
    typedef struct packed {
        logic [7:0] data_byte;
        exp_kind_t  kind;
        logic       on;
        logic [3:0] channel;
        logic [6:0] field_a;
        logic [6:0] field_b;
    } row_t;

    logic                  clk;
    logic                  reset_reg_N;
    logic                  trig_seq;
    logic [7:0]            seq_databyte;
    logic                  cc_strobe;
    midi_pkg::cc_event_t   cc_event;
    logic                  pc_strobe;
    midi_pkg::pc_event_t   pc_event;
    logic                  note_strobe;
    midi_pkg::note_event_t note_event;

    // Table and in-flight checks matched by due cycle
    row_t   stim_table [$];
    row_t   pending_row [$];
    int     pending_due [$];
    int     cycle_count = 0;
    int     timeout_limit = 0;
    int     error_count = 0;
    int     check_count = 0;
    integer seed = 32'h5a1d8e7c;

    midi_cmd_top i_midi_cmd_top (
        .clk          (clk),
        .reset_reg_N  (reset_reg_N),
        .trig_seq     (trig_seq),
        .seq_databyte (seq_databyte),
        .cc_strobe    (cc_strobe),
        .cc_event     (cc_event),
        .pc_strobe    (pc_strobe),
        .pc_event     (pc_event),
        .note_strobe  (note_strobe),
        .note_event   (note_event)
    );

    ////////////////////
    // Clock and cycle count
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the stimulus table did not finish",
                     cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic report_mismatch(input string what);
        error_count++;
        $display("Fail at %0d ns: %s", $time, what);
    endtask

    // Rising edge plus 1 ns where inputs change
    task automatic wait_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic add_row(input logic [7:0] data_byte, input exp_kind_t kind,
                           input logic on, input logic [3:0] channel,
                           input logic [6:0] field_a, input logic [6:0] field_b);
        row_t row;
        row = '{data_byte: data_byte, kind: kind, on: on, channel: channel,
                field_a: field_a, field_b: field_b};
        stim_table.push_back(row);
    endtask

    // Byte that completes nothing
    task automatic add_quiet_byte(input logic [7:0] data_byte);
        add_row(data_byte, EXP_NONE, 1'b0, 4'd0, 7'd0, 7'd0);
    endtask

    // All three strobes and the payload of the expected one
    task automatic check_outputs(input row_t row, input string where);
        midi_pkg::cc_event_t   cc_exp;
        midi_pkg::pc_event_t   pc_exp;
        midi_pkg::note_event_t note_exp;
        cc_exp   = '{channel: row.channel, controller: row.field_a, value: row.field_b};
        pc_exp   = '{channel: row.channel, program_num: row.field_a};
        note_exp = '{on: row.on, channel: row.channel, key: row.field_a,
                     velocity: row.field_b};
        check_count++;
        assert (cc_strobe === (row.kind == EXP_CC))
            else report_mismatch($sformatf("cc_strobe is %b %s", cc_strobe, where));
        assert (pc_strobe === (row.kind == EXP_PC))
            else report_mismatch($sformatf("pc_strobe is %b %s", pc_strobe, where));
        assert (note_strobe === (row.kind == EXP_NOTE))
            else report_mismatch($sformatf("note_strobe is %b %s", note_strobe, where));
        if (row.kind == EXP_CC) begin
            assert (cc_event === cc_exp)
                else report_mismatch($sformatf("cc_event %h, expected %h %s",
                                               cc_event, cc_exp, where));
        end
        if (row.kind == EXP_PC) begin
            assert (pc_event === pc_exp)
                else report_mismatch($sformatf("pc_event %h, expected %h %s",
                                               pc_event, pc_exp, where));
        end
        if (row.kind == EXP_NOTE) begin
            assert (note_event === note_exp)
                else report_mismatch($sformatf("note_event %h, expected %h %s",
                                               note_event, note_exp, where));
        end
    endtask

    // Idle cycles expect all strobes low
    always @(posedge clk) begin
        row_t due_row;
        #1;
        if (pending_due.size() > 0 && pending_due[0] == cycle_count) begin
            void'(pending_due.pop_front());
            due_row = pending_row.pop_front();
            check_outputs(due_row, $sformatf("after byte %h", due_row.data_byte));
        end else begin
            due_row = '0;
            check_outputs(due_row, "on an idle cycle");
        end
    end

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic load_table();
        // Control change then a second one under running status
        add_quiet_byte(8'hB3);
        add_quiet_byte(8'h07);
        add_row(8'h64, EXP_CC, 1'b0, 4'd3, 7'd7, 7'd100);
        add_quiet_byte(8'h0A);
        add_row(8'h20, EXP_CC, 1'b0, 4'd3, 7'd10, 7'd32);
        // Program change with one event per data byte
        add_quiet_byte(8'hC5);
        add_row(8'h01, EXP_PC, 1'b0, 4'd5, 7'd1, 7'd0);
        add_row(8'h02, EXP_PC, 1'b0, 4'd5, 7'd2, 7'd0);
        add_row(8'h03, EXP_PC, 1'b0, 4'd5, 7'd3, 7'd0);
        // Note on, zero velocity under running status, real note off
        add_quiet_byte(8'h92);
        add_quiet_byte(8'h3C);
        add_row(8'h40, EXP_NOTE, 1'b1, 4'd2, 7'd60, 7'd64);
        add_quiet_byte(8'h3C);
        add_row(8'h00, EXP_NOTE, 1'b0, 4'd2, 7'd60, 7'd0);
        add_quiet_byte(8'h82);
        add_quiet_byte(8'h3C);
        add_row(8'h10, EXP_NOTE, 1'b0, 4'd2, 7'd60, 7'd16);
        // Realtime bytes inside a message
        add_quiet_byte(8'hB1);
        add_quiet_byte(8'hF8);
        add_quiet_byte(8'h4A);
        add_quiet_byte(8'hFE);
        add_row(8'h7F, EXP_CC, 1'b0, 4'd1, 7'd74, 7'd127);
        // F0 drops running status until the next status byte
        add_quiet_byte(8'hF0);
        add_quiet_byte(8'h10);
        add_quiet_byte(8'h20);
        add_quiet_byte(8'h93);
        add_quiet_byte(8'h45);
        add_row(8'h00, EXP_NOTE, 1'b0, 4'd3, 7'd69, 7'd0);
        // Pitch bend and channel pressure are skipped
        add_quiet_byte(8'hE0);
        add_quiet_byte(8'h00);
        add_quiet_byte(8'h40);
        add_quiet_byte(8'hD0);
        add_quiet_byte(8'h22);
        add_quiet_byte(8'h9F);
        add_quiet_byte(8'h24);
        add_row(8'h7F, EXP_NOTE, 1'b1, 4'd15, 7'd36, 7'd127);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int gap;
        reset_reg_N  = 1'b0;
        trig_seq     = 1'b0;
        seq_databyte = 8'h00;
        load_table();
        // At most 4 cycles per byte plus reset and drain
        timeout_limit = stim_table.size() * 6 + 100;
        repeat (8) @(posedge clk);
        #1;
        reset_reg_N = 1'b1;

        foreach (stim_table[i]) begin
            trig_seq     = 1'b1;
            seq_databyte = stim_table[i].data_byte;
            pending_due.push_back(cycle_count + 2);
            pending_row.push_back(stim_table[i]);
            wait_drive_slot();
            trig_seq = 1'b0;
            // Zero gap gives back-to-back bytes
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) wait_drive_slot();
        end

        // Drain the last checks then a few quiet cycles
        while (pending_due.size() > 0) begin
            wait_drive_slot();
        end
        repeat (4) wait_drive_slot();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/midi_pkg.sv
logic/midi_status_tracker.sv
logic/controller_cmd_inst.sv
logic/note_cmd_decoder.sv
logic/midi_cmd_top.sv
verification/midi_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MIDI command decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module midi_cmd_tb \
    -Mdir obj_dir -o midi_cmd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/midi_cmd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "Result: passed"
    exit 0
fi
echo "Result: failed, see $LOG"
exit 1
